// ==== hdl/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath sizes
`define RV_XLEN 32 // Integer register width
`define RV_NREGS 32 // Architectural registers x0..x31

// Major opcodes, instr[6:0]
`define RV_OPC_OP 7'b0110011 // Register-register ALU
`define RV_OPC_OPIMM 7'b0010011 // Register-immediate ALU
`define RV_OPC_LUI 7'b0110111 // Load upper immediate

// ALU operation codes
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_SLL 4'd2
`define ALU_SLT 4'd3 // Signed compare
`define ALU_SLTU 4'd4 // Unsigned compare
`define ALU_XOR 4'd5
`define ALU_SRL 4'd6
`define ALU_SRA 4'd7 // Sign-filling shift
`define ALU_OR 4'd8
`define ALU_AND 4'd9
`define ALU_PASSB 4'd10 // Result is operand b, for LUI

`endif

// ==== hdl/rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

	// Plain vectors with a meaning
	typedef logic [`RV_XLEN-1:0] word_t; // Data word
	typedef logic [31:0] instr_t; // Raw instruction, always 32 bits in RV32I
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t; // Register index
	typedef logic [3:0] alu_op_t; // One of the ALU_* codes

	// Decode to execute
	typedef struct packed {
		alu_op_t op; // Operation selected by decode
		word_t a; // rs1 value, or zero
		word_t b; // rs2 value or immediate
		reg_idx_t rd; // Destination
		logic write; // Destination gets written
		logic illegal; // Unsupported encoding
	} dec_op_t;

	// Execute to result, and result to the outside
	typedef struct packed {
		reg_idx_t rd; // Destination
		word_t value; // Computed result
		logic write; // Destination gets written
		logic illegal; // Unsupported encoding
	} result_t;

endpackage

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module reg_file (
	input logic clk,
	input logic rst,
	input rv_pkg::reg_idx_t raddr_a, // rs1 index
	input rv_pkg::reg_idx_t raddr_b, // rs2 index
	output rv_pkg::word_t rdata_a,
	output rv_pkg::word_t rdata_b,
	input logic we, // Commit strobe from result stage
	input rv_pkg::reg_idx_t waddr,
	input rv_pkg::word_t wdata
);

	rv_pkg::word_t mem [`RV_NREGS]; // x0 entry exists but is never written

	// Combinational reads, x0 forced to zero
	always_comb begin
		rdata_a = (raddr_a == '0) ? '0 : mem[raddr_a];
		rdata_b = (raddr_b == '0) ? '0 : mem[raddr_b];
	end

	// Single write port, visible to reads after the edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				mem[i] <= '0; // Whole file cleared
			end
		end else if (we && waddr != '0) begin
			mem[waddr] <= wdata; // Writes to x0 dropped
		end
	end

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module instr_decode (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input rv_pkg::instr_t in_instr,
	output rv_pkg::reg_idx_t raddr_a,
	output rv_pkg::reg_idx_t raddr_b,
	input rv_pkg::word_t rdata_a,
	input rv_pkg::word_t rdata_b,
	input logic ex_busy, // Execute holds a writing instruction
	input logic res_busy, // Result holds a writing instruction
	input rv_pkg::reg_idx_t ex_rd,
	input rv_pkg::reg_idx_t res_rd,
	output logic dec_valid,
	input logic dec_ready,
	output rv_pkg::dec_op_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	rv_pkg::reg_idx_t rs1, rs2;
	rv_pkg::word_t imm_i, imm_u;
	rv_pkg::dec_op_t op_d; // Operation built from in_instr
	logic use_a, use_b; // Which sources are really read
	logic own_busy; // Own register holds a writing instruction
	logic hazard;

	assign opcode = in_instr[6:0];
	assign funct3 = in_instr[14:12];
	assign funct7 = in_instr[31:25];
	assign rs1 = in_instr[19:15];
	assign rs2 = in_instr[24:20];
	assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]}; // Sign-extended
	assign imm_u = {in_instr[31:12], 12'b0};
	assign raddr_a = rs1;
	assign raddr_b = rs2;

	always_comb begin
		op_d = '0;
		op_d.op = `ALU_ADD;
		op_d.rd = in_instr[11:7];
		use_a = 1'b0;
		use_b = 1'b0;
		case (opcode)
			`RV_OPC_OP: begin
				op_d.a = rdata_a;
				op_d.b = rdata_b;
				use_a = 1'b1;
				use_b = 1'b1;
				case (funct3)
					3'b000: op_d.op = funct7[5] ? `ALU_SUB : `ALU_ADD;
					3'b001: op_d.op = `ALU_SLL;
					3'b010: op_d.op = `ALU_SLT;
					3'b011: op_d.op = `ALU_SLTU;
					3'b100: op_d.op = `ALU_XOR;
					3'b101: op_d.op = funct7[5] ? `ALU_SRA : `ALU_SRL;
					3'b110: op_d.op = `ALU_OR;
					default: op_d.op = `ALU_AND;
				endcase
				// Only SUB and SRA accept funct7 0x20
				op_d.illegal = !(funct7 == 7'h00 ||
					(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			`RV_OPC_OPIMM: begin
				op_d.a = rdata_a;
				op_d.b = imm_i; // Shamt sits in the low 5 bits
				use_a = 1'b1;
				case (funct3)
					3'b000: op_d.op = `ALU_ADD;
					3'b001: begin
						op_d.op = `ALU_SLL;
						op_d.illegal = (funct7 != 7'h00);
					end
					3'b010: op_d.op = `ALU_SLT;
					3'b011: op_d.op = `ALU_SLTU;
					3'b100: op_d.op = `ALU_XOR;
					3'b101: begin
						op_d.op = funct7[5] ? `ALU_SRA : `ALU_SRL;
						op_d.illegal = (funct7 != 7'h00 && funct7 != 7'h20);
					end
					3'b110: op_d.op = `ALU_OR;
					default: op_d.op = `ALU_AND;
				endcase
			end
			`RV_OPC_LUI: begin
				op_d.op = `ALU_PASSB;
				op_d.b = imm_u;
			end
			default: op_d.illegal = 1'b1;
		endcase
		if (op_d.illegal) begin
			op_d.op = `ALU_ADD; // Result value is zero
			op_d.a = '0;
			op_d.b = '0;
			use_a = 1'b0; // Illegal ops never stall
			use_b = 1'b0;
		end
		op_d.write = !op_d.illegal; // rd 0 still reports write
	end

	assign own_busy = dec_valid && dec.write;

	// Stall while any older writer in flight targets a used source
	always_comb begin
		hazard = 1'b0;
		if (ex_busy && ex_rd != '0 &&
			((use_a && ex_rd == rs1) || (use_b && ex_rd == rs2))) begin
			hazard = 1'b1;
		end
		if (res_busy && res_rd != '0 &&
			((use_a && res_rd == rs1) || (use_b && res_rd == rs2))) begin
			hazard = 1'b1;
		end
		if (own_busy && dec.rd != '0 &&
			((use_a && dec.rd == rs1) || (use_b && dec.rd == rs2))) begin
			hazard = 1'b1; // Own register, moving to execute
		end
	end

	assign in_ready = (!dec_valid || dec_ready) && !hazard;

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0; // Drained to execute
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			dec <= op_d; // Operands captured at accept
		end
	end

endmodule

// ==== hdl/alu_execute.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module alu_execute (
	input logic clk,
	input logic rst,
	input logic dec_valid,
	output logic dec_ready,
	input rv_pkg::dec_op_t dec,
	output logic ex_valid,
	input logic ex_ready,
	output rv_pkg::result_t ex
);

	rv_pkg::word_t value; // Combinational ALU output
	logic [4:0] shamt;
	rv_pkg::result_t ex_d;

	assign shamt = dec.b[4:0]; // Shift amount from low bits of b

	always_comb begin
		case (dec.op)
			`ALU_ADD: value = dec.a + dec.b;
			`ALU_SUB: value = dec.a - dec.b;
			`ALU_SLL: value = dec.a << shamt;
			`ALU_SLT: begin
				value = '0;
				value[0] = ($signed(dec.a) < $signed(dec.b));
			end
			`ALU_SLTU: begin
				value = '0;
				value[0] = (dec.a < dec.b);
			end
			`ALU_XOR: value = dec.a ^ dec.b;
			`ALU_SRL: value = dec.a >> shamt;
			`ALU_SRA: value = rv_pkg::word_t'($signed(dec.a) >>> shamt);
			`ALU_OR: value = dec.a | dec.b;
			`ALU_AND: value = dec.a & dec.b;
			`ALU_PASSB: value = dec.b; // LUI
			default: value = '0;
		endcase
	end

	// Carry rd and flags alongside the value
	always_comb begin
		ex_d.rd = dec.rd;
		ex_d.value = value;
		ex_d.write = dec.write;
		ex_d.illegal = dec.illegal;
	end

	assign dec_ready = !ex_valid || ex_ready; // Empty or being taken

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else if (dec_valid && dec_ready) begin
			ex_valid <= 1'b1;
		end else if (ex_ready) begin
			ex_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid && dec_ready) begin
			ex <= ex_d;
		end
	end

endmodule

// ==== hdl/writeback_result.sv ====
`timescale 1ns/1ns

module writeback_result (
	input logic clk,
	input logic rst,
	input logic ex_valid,
	output logic ex_ready,
	input rv_pkg::result_t ex,
	output logic res_valid,
	input logic res_ready,
	output rv_pkg::result_t res,
	output logic we, // Register file commit
	output rv_pkg::reg_idx_t waddr,
	output rv_pkg::word_t wdata
);

	logic res_fire; // Output handshake this cycle

	assign res_fire = res_valid && res_ready;

	// Room when empty or the held result leaves now
	assign ex_ready = !res_valid || res_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
		end else if (ex_valid && ex_ready) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid && ex_ready) begin
			res <= ex; // Held until the handshake
		end
	end

	// Commit coincides with the visible result
	// x0 targets still report write but never strobe the file
	assign we = res_fire && res.write && res.rd != '0;
	assign waddr = res.rd;
	assign wdata = res.value;

endmodule

// ==== hdl/int_core_top.sv ====
`timescale 1ns/1ns

module int_core_top (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input rv_pkg::instr_t in_instr,
	output logic res_valid,
	input logic res_ready,
	output rv_pkg::result_t res
);

	rv_pkg::reg_idx_t raddr_a, raddr_b; // Decode read indices
	rv_pkg::word_t rdata_a, rdata_b;
	logic dec_valid, dec_ready;
	rv_pkg::dec_op_t dec;
	logic ex_valid, ex_ready;
	rv_pkg::result_t ex;
	logic we; // Commit on result handshake
	rv_pkg::reg_idx_t waddr;
	rv_pkg::word_t wdata;

	instr_decode u_decode (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_instr (in_instr),
		.raddr_a (raddr_a),
		.raddr_b (raddr_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.ex_busy (ex_valid & ex.write), // Hazard sources
		.res_busy (res_valid & res.write),
		.ex_rd (ex.rd),
		.res_rd (res.rd),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec (dec)
	);

	alu_execute u_execute (
		.clk (clk),
		.rst (rst),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready),
		.dec (dec),
		.ex_valid (ex_valid),
		.ex_ready (ex_ready),
		.ex (ex)
	);

	writeback_result u_result (
		.clk (clk),
		.rst (rst),
		.ex_valid (ex_valid),
		.ex_ready (ex_ready),
		.ex (ex),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res (res),
		.we (we),
		.waddr (waddr),
		.wdata (wdata)
	);

	reg_file u_regs (
		.clk (clk),
		.rst (rst),
		.raddr_a (raddr_a),
		.raddr_b (raddr_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.we (we),
		.waddr (waddr),
		.wdata (wdata)
	);

endmodule

// ==== dv/int_core_assertions.sv ====
`timescale 1ns/1ns

module int_core_assertions (
	input logic clk,
	input logic rst,
	input logic res_valid,
	input logic res_ready,
	input rv_pkg::result_t res,
	input logic we,
	input rv_pkg::reg_idx_t waddr
);

	// Stalled result keeps valid and payload
	a_res_hold: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_ready |=> res_valid && $stable(res))
		else $error("res changed while stalled");

	a_reset_idle: assert property (@(posedge clk) rst |=> !res_valid)
		else $error("res_valid high after reset");

	// Commit only on an output handshake
	a_we_fire: assert property (@(posedge clk) disable iff (rst)
		we |-> res_valid && res_ready)
		else $error("we without res handshake");

	a_no_x0: assert property (@(posedge clk) disable iff (rst) we |-> waddr != '0)
		else $error("write strobe to x0");

endmodule

bind int_core_top int_core_assertions u_assert (
	.clk (clk),
	.rst (rst),
	.res_valid (res_valid),
	.res_ready (res_ready),
	.res (res),
	.we (we),
	.waddr (waddr)
);

// ==== dv/tb_int_core.sv ====
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_int_core;

	localparam int PERIOD = 20;
	localparam int N_INSTR = 2000;
	localparam int STALL_BOUND = 16; // Worst cycles per instruction with margin
	localparam int TIMEOUT_NS = (N_INSTR * STALL_BOUND + 40) * PERIOD;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic in_valid = 1'b0;
	logic in_ready;
	rv_pkg::instr_t in_instr = '0;
	logic res_valid;
	logic res_ready = 1'b0;
	rv_pkg::result_t res;

	logic [31:0] lcg_state = 32'h973cde1d;
	logic in_fire = 1'b0; // Sampled at negedge for the next posedge
	logic reset_checked = 1'b0;
	rv_pkg::word_t shadow [32]; // Model register file
	rv_pkg::instr_t pending [$]; // Accepted, not yet retired
	rv_pkg::instr_t ins;
	rv_pkg::result_t expected;
	int issued = 0;
	int accepted = 0;
	int results = 0;
	int errors = 0;

	int_core_top dut0 (
		.clk (clk),
		.rst (rst),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_instr (in_instr),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res (res)
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Destinations and rs1 in x0..x7 so dependencies are common
	// rs2 sometimes reaches the upper registers to read their reset value
	function automatic rv_pkg::instr_t gen_instr();
		logic [31:0] r;
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		r = next_rand();
		rd = {2'b00, r[10:8]};
		rs1 = {2'b00, r[13:11]};
		rs2 = (r[7:6] == 2'b11) ? {r[24:23], r[16:14]} : {2'b00, r[16:14]};
		f3 = r[19:17];
		imm = r[31:20];
		if (r[3:0] == 4'd0) begin // Roughly 1 in 16 illegal
			case (r[5:4])
				2'd0: return {r[31:7], 7'b0000011}; // Load opcode is not supported
				2'd1: return {7'h01, rs2, rs1, f3, rd, `RV_OPC_OP}; // Bad funct7
				2'd2: return {7'h04, rs2, rs1, 3'b001, rd, `RV_OPC_OPIMM}; // Bad SLLI
				default: return {7'h20, rs2, rs1, 3'b110, rd, `RV_OPC_OP}; // No "OR-sub"
			endcase
		end else if (r[3:0] < 4'd7) begin
			f7 = (r[5] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
			return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
		end else if (r[3:0] < 4'd14) begin
			if (f3 == 3'b001)
				imm[11:5] = 7'h00;
			if (f3 == 3'b101)
				imm[11:5] = r[5] ? 7'h20 : 7'h00; // SRAI or SRLI
			return {imm, rs1, f3, rd, `RV_OPC_OPIMM};
		end
		return {r[31:12], rd, `RV_OPC_LUI};
	endfunction

	// RV32I semantics against the shadow registers
	function automatic rv_pkg::result_t model_result(input rv_pkg::instr_t i);
		logic [6:0] opc, f7;
		logic [2:0] f3;
		logic is_reg, legal;
		logic [4:0] sh;
		rv_pkg::word_t a, b, v;
		rv_pkg::result_t r;
		opc = i[6:0];
		f3 = i[14:12];
		f7 = i[31:25];
		is_reg = (opc == `RV_OPC_OP);
		a = shadow[i[19:15]];
		b = is_reg ? shadow[i[24:20]] : {{20{i[31]}}, i[31:20]};
		sh = b[4:0];
		case (opc)
			`RV_OPC_OP: legal = (f7 == 7'h00) ||
				(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			`RV_OPC_OPIMM: legal = (f3 == 3'd1) ? (f7 == 7'h00) :
				(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
			`RV_OPC_LUI: legal = 1'b1;
			default: legal = 1'b0;
		endcase
		case (f3)
			3'd0: v = (is_reg && f7[5]) ? a - b : a + b;
			3'd1: v = a << sh;
			3'd2: v = {31'b0, $signed(a) < $signed(b)};
			3'd3: v = {31'b0, a < b};
			3'd4: v = a ^ b;
			3'd5: v = f7[5] ? rv_pkg::word_t'($signed(a) >>> sh) : a >> sh;
			3'd6: v = a | b;
			default: v = a & b;
		endcase
		if (opc == `RV_OPC_LUI)
			v = {i[31:12], 12'b0};
		r.rd = i[11:7];
		r.value = v;
		r.write = legal; // rd 0 still reports write
		r.illegal = !legal;
		return r;
	endfunction

	task automatic check_word(input string name, input rv_pkg::word_t exp,
		input rv_pkg::word_t act);
		assert (exp == act) else begin
			errors++;
			$display("error %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	initial begin
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Stimulus held until accepted
	always @(posedge clk) begin
		if (rst) begin
			in_valid <= 1'b0;
			res_ready <= 1'b0;
		end else begin
			if (!in_valid || in_fire) begin
				if (issued < N_INSTR && next_rand() % 8 != 0) begin
					in_valid <= 1'b1;
					in_instr <= gen_instr();
					issued++;
				end else begin
					in_valid <= 1'b0;
				end
			end
			res_ready <= (next_rand() % 4 != 0); // Back-pressure a quarter of cycles
		end
	end

	// Monitor and model at the stable half of the cycle
	always @(negedge clk) begin
		if (rst) begin
			in_fire = 1'b0;
		end else begin
			if (!reset_checked) begin
				assert (res_valid == 1'b0) else begin
					errors++;
					$display("Result valid was high right after reset");
				end
				assert (in_ready == 1'b1) else begin
					errors++;
					$display("Instruction input was not ready right after reset");
				end
				reset_checked = 1'b1;
			end
			if (res_valid && res_ready) begin
				assert (pending.size() > 0) else begin
					errors++;
					$display("A result appeared with no instruction outstanding");
				end
				if (pending.size() > 0) begin
					ins = pending.pop_front(); // Oldest first
					expected = model_result(ins);
					check_word("res.rd", {27'b0, expected.rd}, {27'b0, res.rd});
					check_word("res.write", {31'b0, expected.write}, {31'b0, res.write});
					check_word("res.illegal", {31'b0, expected.illegal},
						{31'b0, res.illegal});
					if (!expected.illegal)
						check_word("res.value", expected.value, res.value);
					if (expected.write && expected.rd != 5'd0)
						shadow[expected.rd] = expected.value;
				end
				results++;
			end
			in_fire = in_valid && in_ready;
			if (in_fire) begin
				pending.push_back(in_instr);
				accepted++;
			end
		end
	end

	initial begin
		for (int k = 0; k < 32; k++)
			shadow[k] = '0; // Matches the cleared register file
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		wait (accepted == N_INSTR && results == N_INSTR);
		repeat (10) @(posedge clk); // Catch stray extra results
		assert (results == accepted && pending.size() == 0) else begin
			errors++;
			$display("Result count %0d does not match accepted count %0d", results, accepted);
		end
		$display("accepted %0d results %0d errors %0d", accepted, results, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not retire all instructions in time");
		$display("accepted %0d results %0d errors %0d", accepted, results, errors);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/writeback_result.sv
hdl/int_core_top.sv
dv/int_core_assertions.sv
dv/tb_int_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_int_core
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
